// ==== include/unaligned_mem_defs.svh ====
// unaligned memory widths
`ifndef UNALIGNED_MEM_DEFS_SVH
`define UNALIGNED_MEM_DEFS_SVH

// byte address, 4 KiB total
`define UM_ADDR_W 12

// one doubleword
`define UM_DATA_W 64

// byte enables per doubleword
`define UM_STRB_W 8

`endif

// ==== rtl/align_ctrl.sv ====
// unaligned access controller
`timescale 1ns/1ps

`include "unaligned_mem_defs.svh"

module align_ctrl import unaligned_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req,
  input  logic      we,
  input  mem_addr_u addr,
  input  data_t     wdata,
  input  strb_t     wstrb,
  output logic      ack,
  output data_t     rdata,
  bank_if.ctrl      even_bank,
  bank_if.ctrl      odd_bank
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BANK_WAIT,
    S_HOST_ACK,
    S_BANK_REL
  } state_t;

  state_t    state_q;
  logic      ack_q;
  data_t     rdata_q;
  logic      even_req_q;
  logic      odd_req_q;

  // latched request
  logic      we_q;
  mem_addr_u addr_q;
  data_t     wdata_q;
  strb_t     wstrb_q;

  mem_addr_u                   addr_hi;
  logic [5:0]                  bit_sh;
  logic [2*`UM_DATA_W-1:0]     wdata_wide;
  logic [2*`UM_STRB_W-1:0]     wstrb_wide;
  logic [2*`UM_DATA_W-1:0]     rdata_wide;
  data_t                       rdata_lo;
  data_t                       rdata_hi;
  logic                        banks_done;

  // second doubleword, wraps past the end of memory
  assign addr_hi.raw = addr_q.raw + `UM_ADDR_W'(8);
  assign bit_sh      = {addr_q.f.offset, 3'b000};

  // spill of the shift lands in the upper half
  assign wdata_wide = {{`UM_DATA_W{1'b0}}, wdata_q} << bit_sh;
  assign wstrb_wide = {{`UM_STRB_W{1'b0}}, wstrb_q} << addr_q.f.offset;

  // first half goes to the bank its parity names
  always_comb begin
    if (!addr_q.f.bank) begin
      even_bank.row   = addr_q.f.row;
      even_bank.wdata = wdata_wide[`UM_DATA_W-1:0];
      even_bank.wmask = wstrb_wide[`UM_STRB_W-1:0];
      odd_bank.row    = addr_hi.f.row;
      odd_bank.wdata  = wdata_wide[2*`UM_DATA_W-1:`UM_DATA_W];
      odd_bank.wmask  = wstrb_wide[2*`UM_STRB_W-1:`UM_STRB_W];
      rdata_lo        = even_bank.rdata;
      rdata_hi        = odd_bank.rdata;
    end else begin
      odd_bank.row    = addr_q.f.row;
      odd_bank.wdata  = wdata_wide[`UM_DATA_W-1:0];
      odd_bank.wmask  = wstrb_wide[`UM_STRB_W-1:0];
      even_bank.row   = addr_hi.f.row;
      even_bank.wdata = wdata_wide[2*`UM_DATA_W-1:`UM_DATA_W];
      even_bank.wmask = wstrb_wide[2*`UM_STRB_W-1:`UM_STRB_W];
      rdata_lo        = odd_bank.rdata;
      rdata_hi        = even_bank.rdata;
    end
  end

  assign rdata_wide = {rdata_hi, rdata_lo} >> bit_sh;

  assign even_bank.req = even_req_q;
  assign odd_bank.req  = odd_req_q;
  assign even_bank.we  = we_q;
  assign odd_bank.we   = we_q;

  // unused bank sits at req=0 ack=0 and always matches
  assign banks_done = (even_bank.ack == even_req_q) && (odd_bank.ack == odd_req_q);

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && req) begin
      we_q    <= we;
      addr_q  <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      ack_q      <= 1'b0;
      rdata_q    <= '0;
      even_req_q <= 1'b0;
      odd_req_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            // nonzero offset needs the other bank as well
            even_req_q <= !addr.f.bank || (addr.f.offset != 3'd0);
            odd_req_q  <= addr.f.bank || (addr.f.offset != 3'd0);
            state_q    <= S_BANK_WAIT;
          end
        end
        S_BANK_WAIT: begin
          if (banks_done) begin
            ack_q   <= 1'b1;
            state_q <= S_HOST_ACK;
            if (!we_q) begin
              rdata_q <= rdata_wide[`UM_DATA_W-1:0];
            end
          end
        end
        S_HOST_ACK: begin
          if (!req) begin
            even_req_q <= 1'b0;
            odd_req_q  <= 1'b0;
            state_q    <= S_BANK_REL;
          end
        end
        S_BANK_REL: begin
          if (banks_done) begin
            ack_q   <= 1'b0;   // both banks back to idle
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign ack   = ack_q;
  assign rdata = rdata_q;

endmodule

// ==== rtl/bank_if.sv ====
// controller to bank handshake
`timescale 1ns/1ps

interface bank_if import unaligned_mem_pkg::*; ();

  logic  req;
  logic  we;
  row_t  row;
  data_t wdata;
  strb_t wmask;
  logic  ack;
  data_t rdata;   // valid while ack high

  modport ctrl (
    output req, we, row, wdata, wmask,
    input  ack, rdata
  );

  modport mem (
    input  req, we, row, wdata, wmask,
    output ack, rdata
  );

endinterface

// ==== rtl/mem_bank.sv ====
// doubleword memory bank
`timescale 1ns/1ps

module mem_bank import unaligned_mem_pkg::*; (
  input logic clk,
  input logic rst_n,
  bank_if.mem bus
);

  localparam int ROWS = 2 ** $bits(row_t);

  data_t mem_q [ROWS];   // contents start undefined
  data_t rdata_q;
  logic  ack_q;
  logic  accept;

  // new request only while ack is low
  assign accept = bus.req && !ack_q;

  // array access happens on the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      if (bus.we) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (bus.wmask[b]) begin
            mem_q[bus.row][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[bus.row];
      end
    end
  end

  // four-phase slave side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (accept) begin
      ack_q <= 1'b1;
    end else if (ack_q && !bus.req) begin
      ack_q <= 1'b0;   // release seen
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

// ==== rtl/unaligned_mem.sv ====
// unaligned 64-bit data memory
`timescale 1ns/1ps

module unaligned_mem import unaligned_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req,
  input  logic      we,
  input  mem_addr_u addr,
  input  data_t     wdata,
  input  strb_t     wstrb,
  output logic      ack,
  output data_t     rdata
);

  // even and odd doubleword indices
  bank_if if_even ();
  bank_if if_odd ();

  align_ctrl i_align_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .ack       (ack),
    .rdata     (rdata),
    .even_bank (if_even.ctrl),
    .odd_bank  (if_odd.ctrl)
  );

  mem_bank i_bank_even (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (if_even.mem)
  );

  mem_bank i_bank_odd (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (if_odd.mem)
  );

endmodule

// ==== rtl/unaligned_mem_pkg.sv ====
// unaligned memory types
package unaligned_mem_pkg;

  `include "unaligned_mem_defs.svh"

  typedef logic [`UM_DATA_W-1:0] data_t;
  typedef logic [`UM_STRB_W-1:0] strb_t;

  // row inside one bank, address minus bank bit and byte offset
  typedef logic [`UM_ADDR_W-5:0] row_t;

  typedef struct packed {
    row_t       row;
    logic       bank;    // doubleword index parity
    logic [2:0] offset;  // byte within the doubleword
  } mem_addr_f_t;

  // same byte address seen as a number or as fields
  typedef union packed {
    logic [`UM_ADDR_W-1:0] raw;
    mem_addr_f_t           f;
  } mem_addr_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f unaligned_mem.f --top-module unaligned_mem_tb \
  -o unaligned_mem_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/unaligned_mem_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "^PASS: all tests$" sim.log && echo "simulation passed" && exit 0 || echo "simulation failed"
exit 1

// ==== testbench/unaligned_mem_chk.sv ====
// host handshake assertions
`timescale 1ns/1ps

module unaligned_mem_chk import unaligned_mem_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      req,
  input logic      ack,
  input mem_addr_u addr,
  input data_t     rdata
);

  int unsigned fail_cnt = 0;   // failed assertions so far

  // host may drop req as soon as it sees ack, so look at req one edge back
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else begin
      fail_cnt++;
      $error("ack rose while req was low");
    end

  rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(rdata))
    else begin
      fail_cnt++;
      $error("rdata changed while ack was high");
    end

  // release takes three cycles end to end
  ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(req, 3) && $past(req, 4) |-> !ack)
    else begin
      fail_cnt++;
      $error("ack still high three cycles after req fell");
    end

  addr_held: assert property (@(posedge clk) disable iff (!rst_n)
    req && $past(req) |-> $stable(addr))
    else begin
      fail_cnt++;
      $error("addr changed while req was high");
    end

endmodule

// ==== testbench/unaligned_mem_tb.sv ====
// unaligned memory testbench
`timescale 1ns/1ps

`include "unaligned_mem_defs.svh"

module unaligned_mem_tb import unaligned_mem_pkg::*; ();

  localparam int MEM_BYTES   = 1 << `UM_ADDR_W;
  localparam int ACK_LIMIT   = 16;
  localparam int N_ACCESS    = 1273;   // all accesses of all tests
  localparam int CYCLE_LIMIT = N_ACCESS * 8 + 200;

  logic      clk;
  logic      rst_n;
  logic      req;
  logic      we;
  mem_addr_u addr;
  data_t     wdata;
  strb_t     wstrb;
  logic      ack;
  data_t     rdata;

  logic [7:0] model [MEM_BYTES];   // byte image of the memory
  int seed      = 22102;
  int cycle_cnt = 0;
  int data_errs = 0;
  int lat_errs  = 0;
  int hs_errs   = 0;

  unaligned_mem i_unaligned_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .ack   (ack),
    .rdata (rdata)
  );

  bind unaligned_mem unaligned_mem_chk i_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .addr  (addr),
    .rdata (rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // every byte depends on its full address
  function automatic data_t fill_word(input int idx);
    data_t d;
    logic [`UM_ADDR_W-1:0] a;
    for (int k = 0; k < 8; k++) begin
      a = `UM_ADDR_W'(idx * 8 + k);
      d[8*k +: 8] = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    end
    return d;
  endfunction

  function automatic data_t model_read(input mem_addr_u a);
    data_t d;
    logic [`UM_ADDR_W-1:0] idx;
    idx = a.raw;
    for (int k = 0; k < 8; k++) begin
      d[8*k +: 8] = model[idx];
      idx++;   // wraps at the end of memory
    end
    return d;
  endfunction

  function automatic void model_write(input mem_addr_u a, input data_t d, input strb_t s);
    logic [`UM_ADDR_W-1:0] idx;
    idx = a.raw;
    for (int k = 0; k < 8; k++) begin
      if (s[k]) model[idx] = d[8*k +: 8];
      idx++;
    end
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      data_errs++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      lat_errs++;
      $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // returns at a falling edge with cycles counted from the request change
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    while (ack !== level && cycles < ACK_LIMIT) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (ack !== level) begin
      hs_errs++;
      $display("ack never went to %b within %0d cycles at %0t", level, ACK_LIMIT, $time);
    end
  endtask

  task automatic host_write(input mem_addr_u a, input data_t d, input strb_t s);
    int cyc;
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    wstrb = s;
    wait_ack(1'b1, cyc);
    check_latency("ack rise cycles", 3, cyc);
    req = 1'b0;
    wait_ack(1'b0, cyc);
    check_latency("ack fall cycles", 3, cyc);
    model_write(a, d, s);
  endtask

  task automatic host_read(input mem_addr_u a, output data_t d);
    int cyc;
    req   = 1'b1;
    we    = 1'b0;
    addr  = a;
    wstrb = '0;
    wait_ack(1'b1, cyc);
    check_latency("ack rise cycles", 3, cyc);
    d   = rdata;   // valid while ack high
    req = 1'b0;
    wait_ack(1'b0, cyc);
    check_latency("ack fall cycles", 3, cyc);
  endtask

  task automatic read_and_check(input mem_addr_u a);
    data_t got;
    host_read(a, got);
    check_data($sformatf("rdata @%h", a.raw), model_read(a), got);
  endtask

  task automatic fill_and_readback();
    mem_addr_u a;
    data_t got;
    for (int i = 0; i < MEM_BYTES / 8; i++) begin
      a.raw = `UM_ADDR_W'(i * 8);
      host_write(a, fill_word(i), '1);
    end
    for (int i = 0; i < MEM_BYTES / 8; i++) begin
      a.raw = `UM_ADDR_W'(i * 8);
      host_read(a, got);
      check_data($sformatf("rdata @%h", a.raw), fill_word(i), got);
    end
  endtask

  task automatic read_each_offset();
    mem_addr_u a;
    for (int off = 1; off < 8; off++) begin
      a.f.row    = row_t'(40 + off * 3);
      a.f.bank   = off[0];
      a.f.offset = off[2:0];
      read_and_check(a);
    end
  endtask

  // both touched doublewords, read back aligned
  task automatic write_each_offset();
    mem_addr_u a;
    mem_addr_u lo;
    mem_addr_u hi;
    for (int off = 1; off < 8; off++) begin
      a.f.row    = row_t'(100 + off);
      a.f.bank   = off[1];
      a.f.offset = off[2:0];
      host_write(a, {$random(seed), $random(seed)}, '1);
      lo          = a;
      lo.f.offset = 3'd0;
      hi.raw      = lo.raw + `UM_ADDR_W'(8);
      read_and_check(lo);
      read_and_check(hi);
    end
  endtask

  task automatic write_with_strobe(input logic [`UM_ADDR_W-1:0] raw, input strb_t s);
    mem_addr_u a;
    mem_addr_u lo;
    mem_addr_u hi;
    a.raw = raw;
    host_write(a, {$random(seed), $random(seed)}, s);
    lo          = a;
    lo.f.offset = 3'd0;
    hi.raw      = lo.raw + `UM_ADDR_W'(8);
    read_and_check(lo);
    read_and_check(hi);
    read_and_check(a);
  endtask

  task automatic wrap_at_end();
    mem_addr_u a;
    mem_addr_u b;
    a.f.row    = '1;   // last doubleword
    a.f.bank   = 1'b1;
    a.f.offset = 3'd3;
    read_and_check(a);
    host_write(a, {$random(seed), $random(seed)}, 8'hf7);
    b.raw = `UM_ADDR_W'('hff8);
    read_and_check(b);
    b.raw = '0;
    read_and_check(b);
    read_and_check(a);
  endtask

  task automatic random_mix();
    mem_addr_u a;
    logic [31:0] r;
    for (int n = 0; n < 200; n++) begin
      r     = $random(seed);
      a.raw = r[`UM_ADDR_W-1:0];
      if (r[12]) begin
        host_write(a, {$random(seed), $random(seed)}, r[23:16]);
      end else begin
        read_and_check(a);
      end
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    fill_and_readback();
    read_each_offset();
    write_each_offset();
    write_with_strobe(`UM_ADDR_W'('h210), 8'h0f);
    write_with_strobe(`UM_ADDR_W'('h238), 8'ha5);
    write_with_strobe(`UM_ADDR_W'('h31b), 8'h3c);
    write_with_strobe(`UM_ADDR_W'('h3a6), 8'h81);
    wrap_at_end();
    random_mix();

    hs_errs = hs_errs + int'(i_unaligned_mem.i_chk.fail_cnt);
    $display("errors: data %0d, latency %0d, handshake %0d", data_errs, lat_errs, hs_errs);
    if (data_errs + lat_errs + hs_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== unaligned_mem.f ====
+incdir+include
rtl/unaligned_mem_pkg.sv
rtl/bank_if.sv
rtl/mem_bank.sv
rtl/align_ctrl.sv
rtl/unaligned_mem.sv
testbench/unaligned_mem_chk.sv
testbench/unaligned_mem_tb.sv
